/* verilog/logic_unit_cfg_pkg.sv */
package logic_unit_cfg_pkg;

    // ------------------------------
    // Datapath sizing
    // ------------------------------

    // Operand and result width
    localparam int DATA_WIDTH = 32;

    // Shift amount covers every bit position of a data word
    localparam int SHAMT_WIDTH = $clog2(DATA_WIDTH);

    // ------------------------------
    // Word types
    // ------------------------------

    // One operand or result word
    typedef logic [DATA_WIDTH-1:0] data_t;

    // Shift distance, one barrel stage per bit
    typedef logic [SHAMT_WIDTH-1:0] shamt_t;

endpackage

/* verilog/logic_unit_op_pkg.sv */
package logic_unit_op_pkg;

    import logic_unit_cfg_pkg::*;

    // ------------------------------
    // Operation encoding
    // ------------------------------

    localparam int OP_WIDTH = 4;

    // Codes 14 and 15 are left unassigned
    typedef enum logic [OP_WIDTH-1:0] {
        OP_AND = 4'd0,
        OP_OR  = 4'd1,
        OP_XOR = 4'd2,
        OP_NOT = 4'd3,
        OP_SLL = 4'd4,
        OP_SRL = 4'd5,
        OP_SRA = 4'd6,
        OP_NOR = 4'd7,
        OP_EQ  = 4'd8,
        OP_NE  = 4'd9,
        OP_LT  = 4'd10,
        OP_GE  = 4'd11,
        OP_LTU = 4'd12,
        OP_GEU = 4'd13
    } logic_op_e;

    // Result class, picks which unit output reaches the response
    typedef enum logic [1:0] {
        CLASS_NONE    = 2'd0,
        CLASS_BITWISE = 2'd1,
        CLASS_SHIFT   = 2'd2,
        CLASS_COMPARE = 2'd3
    } op_class_e;

    function automatic op_class_e op_class(logic_op_e op);
        op_class_e cls;
        case (op)
            OP_AND, OP_OR, OP_XOR, OP_NOT, OP_NOR: cls = CLASS_BITWISE;
            OP_SLL, OP_SRL, OP_SRA:                cls = CLASS_SHIFT;
            OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU: cls = CLASS_COMPARE;
            default:                               cls = CLASS_NONE;
        endcase
        return cls;
    endfunction

    // ------------------------------
    // Request and unit outputs
    // ------------------------------

    // 4 + 32 + 32 + 5 = 73 bits
    typedef struct packed {
        logic_op_e op;
        data_t     operand_a;
        data_t     operand_b;
        shamt_t    shamt;
    } logic_req_t;

    // 32 + 32 + 1 = 65 bits
    typedef struct packed {
        data_t bitwise_result;
        data_t shift_result;
        logic  compare_flag;
    } unit_results_t;

endpackage

/* verilog/bitwise_unit.sv */
module bitwise_unit
    import logic_unit_cfg_pkg::*;
    import logic_unit_op_pkg::*;
(
    input  logic_op_e op,
    input  data_t     operand_a,
    input  data_t     operand_b,
    output data_t     result
);

    // Per-bit logic of the two operands
    data_t and_word;
    data_t or_word;
    data_t xor_word;
    data_t not_word;
    data_t nor_word;

    assign and_word = operand_a & operand_b;
    assign or_word  = operand_a | operand_b;
    assign xor_word = operand_a ^ operand_b;
    // NOT only looks at operand_a
    assign not_word = ~operand_a;
    assign nor_word = ~(operand_a | operand_b);

    // Opcode picks one word
    always_comb begin
        case (op)
            OP_AND:  result = and_word;
            OP_OR:   result = or_word;
            OP_XOR:  result = xor_word;
            OP_NOT:  result = not_word;
            OP_NOR:  result = nor_word;
            // Shift and compare codes belong to other units
            default: result = '0;
        endcase
    end

endmodule

/* verilog/barrel_shifter.sv */
module barrel_shifter
    import logic_unit_cfg_pkg::*;
    import logic_unit_op_pkg::*;
(
    input  logic_op_e op,
    input  data_t     data,
    input  shamt_t    shamt,
    output data_t     result
);

    // ------------------------------
    // Direction and fill decode
    // ------------------------------

    logic is_right;
    logic is_arith;

    assign is_right = (op == OP_SRL) || (op == OP_SRA);
    // Sign fill only on arithmetic right shift
    assign is_arith = (op == OP_SRA);

    // Stage words, index 0 is the (possibly reversed) input
    data_t stage [0:SHAMT_WIDTH];

    // ------------------------------
    // Input reversal
    // ------------------------------

    // Left shift runs as a right shift on the bit-reversed word
    for (genvar j = 0; j < DATA_WIDTH; j++) begin : g_rev_in
        assign stage[0][j] = is_right ? data[j] : data[DATA_WIDTH-1-j];
    end

    // ------------------------------
    // Log stages
    // ------------------------------

    for (genvar i = 0; i < SHAMT_WIDTH; i++) begin : g_stage
        localparam int STEP = 1 << i;

        logic fill;

        // Top bit of this stage still holds the sign
        assign fill = is_arith & stage[i][DATA_WIDTH-1];

        // Move down by STEP when the matching shamt bit is set
        assign stage[i+1] = shamt[i]
                          ? {{STEP{fill}}, stage[i][DATA_WIDTH-1:STEP]}
                          : stage[i];
    end

    // ------------------------------
    // Output reversal
    // ------------------------------

    // Undo the reversal for left shifts
    for (genvar j = 0; j < DATA_WIDTH; j++) begin : g_rev_out
        assign result[j] = is_right ? stage[SHAMT_WIDTH][j]
                                    : stage[SHAMT_WIDTH][DATA_WIDTH-1-j];
    end

endmodule

/* verilog/subtractor.sv */
module subtractor
    import logic_unit_cfg_pkg::*;
(
    input  data_t minuend,
    input  data_t subtrahend,
    output data_t difference,
    output logic  borrow
);

    // Borrow into each bit, entry 0 is the chain input
    logic [DATA_WIDTH:0] borrow_chain;

    assign borrow_chain[0] = 1'b0;

    for (genvar i = 0; i < DATA_WIDTH; i++) begin : g_bit
        logic a_bit;
        logic b_bit;

        assign a_bit = minuend[i];
        assign b_bit = subtrahend[i];

        // Full-subtractor difference
        assign difference[i] = a_bit ^ b_bit ^ borrow_chain[i];

        // Borrow out when b plus incoming borrow exceeds a
        assign borrow_chain[i+1] = (~a_bit & b_bit)
                                 | (~a_bit & borrow_chain[i])
                                 | (b_bit & borrow_chain[i]);
    end

    // Set when minuend is below subtrahend, unsigned
    assign borrow = borrow_chain[DATA_WIDTH];

endmodule

/* verilog/comparator.sv */
module comparator
    import logic_unit_cfg_pkg::*;
    import logic_unit_op_pkg::*;
(
    input  logic_op_e op,
    input  data_t     operand_a,
    input  data_t     operand_b,
    output logic      flag
);

    data_t diff;
    logic  borrow;
    logic  not_equal;
    logic  sign_diff;
    logic  less_signed;

    // a - b for the order flags
    subtractor i_subtractor (
        .minuend    (operand_a),
        .subtrahend (operand_b),
        .difference (diff),
        .borrow     (borrow)
    );

    // Any differing bit means not equal
    assign not_equal = |(operand_a ^ operand_b);

    // Signs disagree, so the negative operand is the smaller one
    assign sign_diff = operand_a[DATA_WIDTH-1] ^ operand_b[DATA_WIDTH-1];

    // Same signs cannot overflow, so the difference sign decides
    assign less_signed = sign_diff ? operand_a[DATA_WIDTH-1] : diff[DATA_WIDTH-1];

    // One flag per compare opcode
    always_comb begin
        case (op)
            OP_EQ:   flag = ~not_equal;
            OP_NE:   flag = not_equal;
            OP_LT:   flag = less_signed;
            OP_GE:   flag = ~less_signed;
            // Unsigned order straight from the borrow
            OP_LTU:  flag = borrow;
            OP_GEU:  flag = ~borrow;
            default: flag = 1'b0;
        endcase
    end

endmodule

/* verilog/result_stage.sv */
module result_stage
    import logic_unit_cfg_pkg::*;
    import logic_unit_op_pkg::*;
(
    input  logic          clk,
    input  logic          arst_n,
    input  logic          req_valid,
    input  logic_op_e     op,
    input  unit_results_t units,
    output logic          rsp_valid,
    output data_t         rsp_result
);

    // ------------------------------
    // Result select
    // ------------------------------

    op_class_e cls;
    data_t     selected;

    assign cls = op_class(op);

    always_comb begin
        case (cls)
            CLASS_BITWISE: selected = units.bitwise_result;
            CLASS_SHIFT:   selected = units.shift_result;
            // Flag lands in bit 0, upper bits cleared
            CLASS_COMPARE: selected = {{(DATA_WIDTH-1){1'b0}}, units.compare_flag};
            // Codes 14 and 15
            default:       selected = '0;
        endcase
    end

    // ------------------------------
    // Response register
    // ------------------------------

    // One-cycle latency from strobe to response
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rsp_valid  <= 1'b0;
            rsp_result <= '0;
        end else begin
            // Strobe is a single-cycle pulse, mirrored one cycle later
            rsp_valid <= req_valid;
            // Last result held between requests
            if (req_valid) begin
                rsp_result <= selected;
            end
        end
    end

endmodule

/* verilog/logic_unit.sv */
module logic_unit
    import logic_unit_cfg_pkg::*;
    import logic_unit_op_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       req_valid,
    input  logic_req_t req,
    output logic       rsp_valid,
    output data_t      rsp_result
);

    // Unit outputs before they are bundled
    data_t         bitwise_result;
    data_t         shift_result;
    logic          compare_flag;
    unit_results_t units;

    // ------------------------------
    // Combinational units
    // ------------------------------

    bitwise_unit i_bitwise_unit (
        .op        (req.op),
        .operand_a (req.operand_a),
        .operand_b (req.operand_b),
        .result    (bitwise_result)
    );

    // Shifts always act on operand_a
    barrel_shifter i_barrel_shifter (
        .op     (req.op),
        .data   (req.operand_a),
        .shamt  (req.shamt),
        .result (shift_result)
    );

    comparator i_comparator (
        .op        (req.op),
        .operand_a (req.operand_a),
        .operand_b (req.operand_b),
        .flag      (compare_flag)
    );

    assign units = '{
        bitwise_result: bitwise_result,
        shift_result:   shift_result,
        compare_flag:   compare_flag
    };

    // ------------------------------
    // Select and register
    // ------------------------------

    result_stage i_result_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .op         (req.op),
        .units      (units),
        .rsp_valid  (rsp_valid),
        .rsp_result (rsp_result)
    );

endmodule

/* bench/tb_logic_unit.sv */
module tb_logic_unit
    import logic_unit_cfg_pkg::*;
    import logic_unit_op_pkg::*;
();

    // ------------------------------
    // Timing and limits
    // ------------------------------

    localparam int HALF_PERIOD  = 50;
    localparam int DRIVE_DELAY  = 10;
    localparam int RESET_CYCLES = 16;
    // Traffic is about 670 cycles, one per request plus reset and idle gaps
    localparam int TIMEOUT_CYCLES = 2000;

    logic       clk = 1'b0;
    logic       arst_n;
    logic       req_valid;
    logic_req_t req;
    logic       rsp_valid;
    data_t      rsp_result;

    int seed = 71125;
    int cycle_count = 0;
    int value_errors = 0;
    int protocol_errors = 0;

    logic_unit i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_result (rsp_result)
    );

    always #HALF_PERIOD clk = ~clk;

    // Hard stop if the sequence stalls
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run went past %0d cycles without finishing", TIMEOUT_CYCLES);
            $display("*** TEST FAILED ***");
            $finish;
        end
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    // Plain operators, compare flags land in bit 0
    function automatic data_t model_result(logic_op_e op, data_t a, data_t b, shamt_t shamt);
        data_t result;
        case (op)
            OP_AND:  result = a & b;
            OP_OR:   result = a | b;
            OP_XOR:  result = a ^ b;
            OP_NOT:  result = ~a;
            OP_NOR:  result = ~(a | b);
            OP_SLL:  result = a << shamt;
            OP_SRL:  result = a >> shamt;
            OP_SRA:  result = $unsigned($signed(a) >>> shamt);
            OP_EQ:   result = data_t'(a == b);
            OP_NE:   result = data_t'(a != b);
            OP_LT:   result = data_t'($signed(a) < $signed(b));
            OP_GE:   result = data_t'($signed(a) >= $signed(b));
            OP_LTU:  result = data_t'(a < b);
            OP_GEU:  result = data_t'(a >= b);
            default: result = '0;
        endcase
        return result;
    endfunction

    // ------------------------------
    // Driving and checking
    // ------------------------------

    task automatic check_value(string name, data_t expected, data_t actual);
        if (expected !== actual) begin
            value_errors++;
            $display("ERROR %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // Inputs change a little after the rising edge
    task automatic wait_drive_point();
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic drive_request(logic_op_e op, data_t a, data_t b, shamt_t shamt);
        req_valid     = 1'b1;
        req.op        = op;
        req.operand_a = a;
        req.operand_b = b;
        req.shamt     = shamt;
    endtask

    // Response must be present exactly one edge after the request
    task automatic check_response(string name, data_t expected);
        if (rsp_valid !== 1'b1) begin
            protocol_errors++;
            $display("No response one cycle after request %s", name);
        end else begin
            check_value(name, expected, rsp_result);
        end
    endtask

    task automatic check_no_response(string where);
        if (rsp_valid !== 1'b0) begin
            protocol_errors++;
            $display("Unexpected rsp_valid high %s", where);
        end
    endtask

    task automatic run_request(string name, logic_op_e op, data_t a, data_t b, shamt_t shamt);
        data_t expected;
        expected = model_result(op, a, b, shamt);
        drive_request(op, a, b, shamt);
        wait_drive_point();
        req_valid = 1'b0;
        check_response(name, expected);
    endtask

    // ------------------------------
    // Directed tests
    // ------------------------------

    task automatic test_reset_idle();
        for (int c = 0; c < RESET_CYCLES; c++) begin
            wait_drive_point();
            check_no_response("during reset");
            check_value("reset result", '0, rsp_result);
        end
        arst_n = 1'b1;
        for (int c = 0; c < 4; c++) begin
            wait_drive_point();
            check_no_response("while idle after reset");
            check_value("idle result", '0, rsp_result);
        end
    endtask

    task automatic run_bitwise_pair(string tag, data_t a, data_t b);
        run_request({"AND ", tag}, OP_AND, a, b, '0);
        run_request({"OR ", tag}, OP_OR, a, b, '0);
        run_request({"XOR ", tag}, OP_XOR, a, b, '0);
        run_request({"NOT ", tag}, OP_NOT, a, b, '0);
        run_request({"NOR ", tag}, OP_NOR, a, b, '0);
    endtask

    task automatic test_bitwise();
        run_bitwise_pair("ones", '1, '1);
        run_bitwise_pair("zeros", '0, '0);
        run_bitwise_pair("alternating", 32'haaaa_aaaa, 32'h5555_5555);
        run_bitwise_pair("ones vs alternating", '1, 32'h5555_5555);
        for (int n = 0; n < 40; n++) begin
            run_bitwise_pair($sformatf("random %0d", n), $random(seed), $random(seed));
        end
    endtask

    // Every distance for each shift kind
    task automatic run_shift_sweep(string tag, data_t a);
        for (int k = 0; k < DATA_WIDTH; k++) begin
            run_request($sformatf("SLL %s by %0d", tag, k), OP_SLL, a, '0, shamt_t'(k));
            run_request($sformatf("SRL %s by %0d", tag, k), OP_SRL, a, '0, shamt_t'(k));
            run_request($sformatf("SRA %s by %0d", tag, k), OP_SRA, a, '0, shamt_t'(k));
        end
    endtask

    task automatic test_shifts();
        run_shift_sweep("top set", 32'hc3a5_0f81);
        run_shift_sweep("top clear", 32'h5a3c_f00d);
    endtask

    // Full-word check, so any set upper bit shows up as a mismatch
    task automatic run_compare_pair(string tag, data_t a, data_t b);
        string name;
        logic_op_e ops [6] = '{OP_EQ, OP_NE, OP_LT, OP_GE, OP_LTU, OP_GEU};
        for (int n = 0; n < 6; n++) begin
            name = {ops[n].name(), " ", tag};
            run_request(name, ops[n], a, b, '0);
        end
    endtask

    task automatic test_compares();
        data_t same;
        same = $random(seed);
        run_compare_pair("equal", same, same);
        run_compare_pair("min vs one", 32'h8000_0000, 32'h1);
        run_compare_pair("one vs min", 32'h1, 32'h8000_0000);
        run_compare_pair("ones vs zero", '1, '0);
        run_compare_pair("zero vs ones", '0, '1);
        for (int n = 0; n < 30; n++) begin
            run_compare_pair($sformatf("random %0d", n), $random(seed), $random(seed));
        end
    endtask

    task automatic test_unused_ops();
        run_request("opcode 14", logic_op_e'(4'd14), '1, '1, '1);
        run_request("opcode 15", logic_op_e'(4'd15), '1, 32'h1234_5678, '1);
    endtask

    // Twenty strobes in a row, each checked on the next edge
    task automatic test_back_to_back();
        data_t     a;
        data_t     b;
        data_t     rand_word;
        logic_op_e op;
        shamt_t    shamt;
        data_t     expected;
        for (int n = 0; n < 20; n++) begin
            rand_word = $random(seed);
            op        = logic_op_e'(rand_word[3:0]);
            shamt     = rand_word[8:4];
            a         = $random(seed);
            b         = $random(seed);
            expected  = model_result(op, a, b, shamt);
            drive_request(op, a, b, shamt);
            wait_drive_point();
            check_response($sformatf("burst %0d", n), expected);
        end
        req_valid = 1'b0;
        // Idle request bits that would load the inverse of the last result
        req.op        = OP_NOT;
        req.operand_a = expected;
        wait_drive_point();
        check_no_response("after back-to-back burst");
        check_value("held result after burst", expected, rsp_result);
    endtask

    // ------------------------------
    // Sequence and verdict
    // ------------------------------

    initial begin
        arst_n    = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        #DRIVE_DELAY;
        test_reset_idle();
        test_bitwise();
        test_shifts();
        test_compares();
        test_unused_ops();
        test_back_to_back();
        wait_drive_point();
        $display("Checks done: %0d value errors, %0d protocol errors",
                 value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* sources.f */
verilog/logic_unit_cfg_pkg.sv
verilog/logic_unit_op_pkg.sv
verilog/bitwise_unit.sv
verilog/barrel_shifter.sv
verilog/subtractor.sv
verilog/comparator.sv
verilog/result_stage.sv
verilog/logic_unit.sv
bench/tb_logic_unit.sv

/* Makefile */
TOP := tb_logic_unit
LOG := sim.log

.PHONY: all run lint clean

all: run

obj_dir/V$(TOP): sources.f $(wildcard verilog/*.sv) $(wildcard bench/*.sv)
	verilator --binary --timing --top-module $(TOP) -f sources.f

# The log decides pass or fail
run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

lint:
	verilator --lint-only --timing --top-module logic_unit -f sources.f

clean:
	rm -rf obj_dir $(LOG)
